// File: pll_cfg_pkg.sv
/* Field layout of the four 32-bit synthesizer configuration words.
   Word 3 is a plain loop-filter word and has no field struct. */
package pll_cfg_pkg;

  // Word 0 holds the post-scaler dividers, stored and read back only
  typedef struct packed {
    logic [5:0] ps1_l2_frac;  // Bits 31..26
    logic [7:0] ps1_l2_int;   // Bits 25..18
    logic [5:0] ps0_l2_frac;  // Bits 17..12
    logic [7:0] ps0_l2_int;   // Bits 11..4
    logic [1:0] ps1_l1;       // Bits 3..2
    logic [1:0] ps0_l1;       // Bits 1..0
  } pll_cfg0_t;

  // Word 1 is the multiplier and output control
  typedef struct packed {
    logic [3:0]  prescale;      // Reference divide minus one
    logic        integer_mode;  // Stored only
    logic [11:0] mul_frac;      // Low part of the NCO increment
    logic [10:0] mul_int;       // High part of the NCO increment
    logic        ps1_bypass;    // Stored only
    logic        ps0_bypass;    // Output follows ref_clk
    logic        ps1_en;        // Stored only
    logic        ps0_en;        // Oscillator run
  } pll_cfg1_t;

  // Word 2 is the lock detect and spread-spectrum setup
  typedef struct packed {
    logic [1:0]  spare;        // Bit 30 feeds the loop-filter capture
    logic [10:0] ssc_period;   // Stored only
    logic [7:0]  ssc_step;     // Stored only
    logic        ssc_en;       // Stored only
    logic [9:0]  ldet_config;  // Lock timer load value
  } pll_cfg2_t;

  typedef enum logic [1:0] {
    WORD_PS   = 2'd0,
    WORD_MUL  = 2'd1,
    WORD_LDET = 2'd2,
    WORD_LF   = 2'd3
  } pll_word_sel_e;

  localparam pll_cfg0_t CFG0_RESET = '0;

  // Both post-scalers start in bypass
  localparam pll_cfg1_t CFG1_RESET = '{
    prescale:     4'd0,
    integer_mode: 1'b0,
    mul_frac:     12'd0,
    mul_int:      11'd0,
    ps1_bypass:   1'b1,
    ps0_bypass:   1'b1,
    ps1_en:       1'b0,
    ps0_en:       1'b0
  };

  localparam pll_cfg2_t   CFG2_RESET = '0;
  localparam logic [31:0] CFG3_RESET = 32'h0000_0000;

endpackage

// File: cfg_bus_pkg.sv
/* Configuration bus shared by the decoder, channels and merge.
   Plain level request with a one-edge acknowledge, no back-pressure. */
package cfg_bus_pkg;

  localparam int CHAN_W = 6;   // Up to 64 channels
  localparam int DATA_W = 32;  // Configuration word width

  typedef struct packed {
    logic                       req;    // Held until ack is seen
    logic                       web;    // Low for write
    logic [CHAN_W-1:0]          chan;   // Target channel
    pll_cfg_pkg::pll_word_sel_e word;   // Word within the channel
    logic [DATA_W-1:0]          wdata;
  } cfg_req_t;

  typedef struct packed {
    logic              ack;
    logic [DATA_W-1:0] rdata;  // Valid with ack on reads
  } cfg_rsp_t;

endpackage

// File: cfg_bus_decoder.sv
/* Combinational request steering. Channels at or above N_CHANNELS
   see no req, so those accesses are never acknowledged. */
`timescale 1ns/10ps

module cfg_bus_decoder #(
  parameter int N_CHANNELS = 4
) (
  input  cfg_bus_pkg::cfg_req_t cfg_req,
  output cfg_bus_pkg::cfg_req_t chan_req [N_CHANNELS]
);

  always_comb begin
    for (int i = 0; i < N_CHANNELS; i++) begin
      chan_req[i]     = cfg_req;  // Fields go to every channel
      chan_req[i].req = cfg_req.req && (int'(cfg_req.chan) == i);  // Unpopulated channels match no entry
    end
  end

endmodule

// File: pll_nco.sv
/* Behavioral synthesizer; ref_clk is a level sampled on clk, not a real clock.
   Bypass wins over ps0_en. Output changes only on clk edges. */
`timescale 1ns/10ps

module pll_nco (
  input  logic                   clk,
  input  logic                   RSTB,
  input  pll_cfg_pkg::pll_cfg1_t cfg1,
  input  logic                   ref_clk,
  output logic                   fll_clk
);

  localparam int ACC_W = 24;

  logic [ACC_W-1:0] acc;        // Phase accumulator
  logic [ACC_W-1:0] acc_nxt;
  logic [3:0]       presc_cnt;  // Counts down to the next add
  logic             running;
  logic             tick;

  assign running = cfg1.ps0_en && !cfg1.ps0_bypass;
  assign tick    = (presc_cnt == 4'd0);
  assign acc_nxt = tick ? acc + {1'b0, cfg1.mul_int, cfg1.mul_frac} : acc;

  always_ff @(posedge clk, negedge RSTB) begin
    if (!RSTB) begin
      presc_cnt <= 4'd0;
      acc       <= '0;
      fll_clk   <= 1'b0;
    end else if (running) begin
      presc_cnt <= tick ? cfg1.prescale : presc_cnt - 4'd1;  // Reload on wrap
      acc       <= acc_nxt;
      fll_clk   <= acc_nxt[ACC_W-1];                          // Top bit is the clock
    end else begin
      // Idle, so the first add after enable comes prescale+1 edges later
      presc_cnt <= cfg1.prescale;
      acc       <= '0;
      fll_clk   <= cfg1.ps0_bypass ? ref_clk : 1'b0;
    end
  end

endmodule

// File: pll_channel.sv
/* One synthesizer channel with its four-word register bank and lock timer.
   Loop filter, spread spectrum and post-scaler 1 fields are stored only. */
`timescale 1ns/10ps

module pll_channel (
  input  logic                  clk,
  input  logic                  RSTB,
  input  cfg_bus_pkg::cfg_req_t req,
  input  logic                  ref_clk,
  input  logic                  pwd,
  output cfg_bus_pkg::cfg_rsp_t rsp,
  output logic                  fll_clk,
  output logic                  lock
);

  import pll_cfg_pkg::*;

  pll_cfg0_t   cfg0;
  pll_cfg1_t   cfg1;
  pll_cfg2_t   cfg2;
  logic [31:0] cfg3;      // Loop filter word
  logic        lf_bit;    // Word 2 bit 30 as of the last word 3 write
  logic [9:0]  ldet_cnt;  // Lock countdown
  logic        wr_en;
  logic        rd_en;
  logic        relock;
  pll_cfg2_t   wr_cfg2;

  assign wr_en   = req.req && !req.web;
  assign rd_en   = req.req && req.web;
  assign wr_cfg2 = pll_cfg2_t'(req.wdata);

  // Any change to multiplier or lock setup restarts the lock timer
  assign relock = wr_en && (req.word == WORD_MUL || req.word == WORD_LDET);

  always_ff @(posedge clk, negedge RSTB) begin
    if (!RSTB) begin
      cfg0   <= CFG0_RESET;
      cfg1   <= CFG1_RESET;
      cfg2   <= CFG2_RESET;
      cfg3   <= CFG3_RESET;
      lf_bit <= 1'b0;
    end else if (wr_en) begin
      case (req.word)
        WORD_PS:   cfg0 <= pll_cfg0_t'(req.wdata);
        WORD_MUL:  cfg1 <= pll_cfg1_t'(req.wdata);
        WORD_LDET: cfg2 <= wr_cfg2;
        WORD_LF: begin
          cfg3   <= req.wdata;
          lf_bit <= cfg2.spare[0];  // Old bit 30, not this write's data
        end
        default: cfg3 <= cfg3;
      endcase
    end
  end

  // Ack follows req by one edge, read data is registered with it
  always_ff @(posedge clk, negedge RSTB) begin
    if (!RSTB) begin
      rsp <= '0;
    end else begin
      rsp.ack <= req.req;
      if (rd_en) begin
        case (req.word)
          WORD_PS:   rsp.rdata <= cfg0;
          WORD_MUL:  rsp.rdata <= cfg1;
          WORD_LDET: rsp.rdata <= {lock, lf_bit, cfg2[29:0]};
          WORD_LF:   rsp.rdata <= cfg3;
          default:   rsp.rdata <= '0;
        endcase
      end
    end
  end

  // Lock rises ldet_config+1 edges after a relock or the end of pwd
  always_ff @(posedge clk, negedge RSTB) begin
    if (!RSTB) begin
      ldet_cnt <= 10'd0;
      lock     <= 1'b0;
    end else if (pwd || relock) begin
      lock     <= 1'b0;
      ldet_cnt <= (wr_en && req.word == WORD_LDET) ? wr_cfg2.ldet_config
                                                   : cfg2.ldet_config;
    end else if (ldet_cnt != 10'd0) begin
      ldet_cnt <= ldet_cnt - 10'd1;
    end else begin
      lock <= 1'b1;
    end
  end

  pll_nco u_nco (
    .clk     (clk),
    .RSTB    (RSTB),
    .cfg1    (cfg1),
    .ref_clk (ref_clk),
    .fll_clk (fll_clk)
  );

endmodule

// File: cfg_status_merge.sv
/* Combinational response merge. Only one channel acks at a time,
   so read data is an ack-gated OR across channels. */
`timescale 1ns/10ps

module cfg_status_merge #(
  parameter int N_CHANNELS = 4
) (
  input  cfg_bus_pkg::cfg_rsp_t chan_rsp [N_CHANNELS],
  input  logic [N_CHANNELS-1:0] chan_lock,
  output cfg_bus_pkg::cfg_rsp_t cfg_rsp,
  output logic [N_CHANNELS-1:0] lock
);

  import cfg_bus_pkg::*;

  always_comb begin
    cfg_rsp = '0;
    for (int i = 0; i < N_CHANNELS; i++) begin
      cfg_rsp.ack   = cfg_rsp.ack | chan_rsp[i].ack;
      // Idle channels hold stale rdata, mask it out
      cfg_rsp.rdata = cfg_rsp.rdata | (chan_rsp[i].rdata & {DATA_W{chan_rsp[i].ack}});
    end
  end

  assign lock = chan_lock;  // One flag per channel

endmodule

// File: pll_cluster.sv
/* Cluster of N_CHANNELS synthesizer channels behind one config bus.
   N_CHANNELS is limited to 64 by the channel field width. */
`timescale 1ns/10ps

module pll_cluster #(
  parameter int N_CHANNELS = 4
) (
  input  logic                  clk,
  input  logic                  RSTB,
  input  cfg_bus_pkg::cfg_req_t cfg_req,
  output cfg_bus_pkg::cfg_rsp_t cfg_rsp,
  input  logic [N_CHANNELS-1:0] ref_clk,
  input  logic [N_CHANNELS-1:0] pwd,
  output logic [N_CHANNELS-1:0] fll_clk,
  output logic [N_CHANNELS-1:0] lock
);

  import cfg_bus_pkg::*;

  cfg_req_t              chan_req [N_CHANNELS];
  cfg_rsp_t              chan_rsp [N_CHANNELS];
  logic [N_CHANNELS-1:0] chan_lock;

  cfg_bus_decoder #(
    .N_CHANNELS (N_CHANNELS)
  ) u_decoder (
    .cfg_req  (cfg_req),
    .chan_req (chan_req)
  );

  for (genvar g = 0; g < N_CHANNELS; g++) begin : g_chan
    pll_channel u_chan (
      .clk     (clk),
      .RSTB    (RSTB),
      .req     (chan_req[g]),
      .ref_clk (ref_clk[g]),
      .pwd     (pwd[g]),
      .rsp     (chan_rsp[g]),
      .fll_clk (fll_clk[g]),
      .lock    (chan_lock[g])
    );
  end

  cfg_status_merge #(
    .N_CHANNELS (N_CHANNELS)
  ) u_merge (
    .chan_rsp  (chan_rsp),
    .chan_lock (chan_lock),
    .cfg_rsp   (cfg_rsp),
    .lock      (lock)
  );

endmodule

// File: pll_checker.sv
/* Watches the pll_cluster ports and keeps its own model of every channel.
   Test op codes must match the values driven by tb_pll_cluster. */
`timescale 1ns/10ps

module pll_checker #(
  parameter int N_CHANNELS = 4
) (
  input  logic                  clk,
  input  logic                  RSTB,
  input  cfg_bus_pkg::cfg_req_t cfg_req,
  input  cfg_bus_pkg::cfg_rsp_t cfg_rsp,
  input  logic [N_CHANNELS-1:0] ref_clk,
  input  logic [N_CHANNELS-1:0] fll_clk,
  input  logic [N_CHANNELS-1:0] lock,
  input  logic [7:0]            test_id,
  input  logic [3:0]            op,
  input  logic [5:0]            chan,
  input  logic [15:0]           exp_val,
  input  logic                  test_end,
  output int                    n_tests,
  output int                    n_fail,
  output int                    n_err
);

  import cfg_bus_pkg::*;

  localparam logic [3:0]  OP_BYP    = 4'd2;
  localparam logic [3:0]  OP_MEAS   = 4'd3;
  localparam logic [3:0]  OP_LOCK   = 4'd4;
  localparam logic [3:0]  OP_PWD    = 4'd5;
  localparam logic [31:0] WORD1_RST = 32'h0000_000C;  // Both bypass bits

  logic [31:0]           model [N_CHANNELS][4];
  logic                  lf_model [N_CHANNELS];  // Word 2 bit 30 at last word 3 write
  logic [N_CHANNELS-1:0] ref_d;
  logic [N_CHANNELS-1:0] fll_d;
  logic [N_CHANNELS-1:0] lock_d;
  logic                  pend;
  logic                  pend_rd;
  logic                  oor_pend;
  logic                  in_range;
  logic                  wr_seen;
  logic                  rise_seen;
  logic [31:0]           pend_exp;
  int                    cyc;
  int                    wr_cyc;
  int                    meas_cnt;
  int                    byp_n;
  int                    test_errs;
  int                    c;
  int                    ch;
  int                    wd;

  initial begin
    n_tests   = 0;
    n_fail    = 0;
    n_err     = 0;
    cyc       = 0;
    test_errs = 0;
  end

  task automatic report_value(input string what, input logic [31:0] got,
                              input logic [31:0] want);
    $display("ERROR at %0t: test %0d %s is 0x%08h, expected 0x%08h",
             $time, test_id, what, got, want);
    test_errs++;
  endtask

  task automatic report_plain(input string msg);
    $display("Test %0d at %0t: %s", test_id, $time, msg);
    test_errs++;
  endtask

  always @(posedge clk) begin
    cyc++;
    c = int'(chan);
    if (!RSTB) begin
      for (int i = 0; i < N_CHANNELS; i++) begin
        model[i][0] = '0;
        model[i][1] = WORD1_RST;
        model[i][2] = '0;
        model[i][3] = '0;
        lf_model[i] = 1'b0;
      end
      pend      = 1'b0;
      oor_pend  = 1'b0;
      wr_seen   = 1'b0;
      rise_seen = 1'b0;
      meas_cnt  = 0;
      byp_n     = 0;
    end else begin
      // Response to the access sampled on the previous edge
      if (pend && !cfg_rsp.ack) begin
        report_plain("no acknowledge one edge after the request");
      end else if (pend && pend_rd && cfg_rsp.rdata !== pend_exp) begin
        report_value("read data", cfg_rsp.rdata, pend_exp);
      end
      if (oor_pend && cfg_rsp.ack) begin
        report_plain("a request to a missing channel was acknowledged");
      end

      // Lock rise is checked before a new write can restart the timer
      if (op == OP_LOCK && c < N_CHANNELS && wr_seen && !rise_seen &&
          !lock_d[c] && lock[c]) begin
        rise_seen = 1'b1;
        if (cyc - 1 - wr_cyc != int'(exp_val)) begin
          report_value("lock delay in edges", 32'(cyc - 1 - wr_cyc), 32'(exp_val));
        end
      end

      ch       = int'(cfg_req.chan);
      wd       = int'(cfg_req.word);
      in_range = ch < N_CHANNELS;
      pend     = cfg_req.req && in_range;
      pend_rd  = cfg_req.web;
      oor_pend = cfg_req.req && !in_range;
      if (pend && cfg_req.web) begin
        pend_exp = model[ch][wd];
        if (wd == 2) pend_exp = {lock[ch], lf_model[ch], model[ch][2][29:0]};
      end
      if (pend && !cfg_req.web) begin
        if (wd == 3) lf_model[ch] = model[ch][2][30];  // Old bit 30
        model[ch][wd] = cfg_req.wdata;
        if (op == OP_LOCK && ch == c && (wd == 1 || wd == 2)) begin
          wr_cyc  = cyc;
          wr_seen = 1'b1;
        end
      end

      if (op == OP_MEAS && !test_end && c < N_CHANNELS && fll_clk[c] && !fll_d[c]) begin
        meas_cnt++;
      end
      if (op == OP_BYP && c < N_CHANNELS) begin
        byp_n++;
        if (byp_n > 2 && fll_clk[c] !== ref_d[c]) begin
          report_value("bypass fll_clk", 32'(fll_clk[c]), 32'(ref_d[c]));
        end
      end

      if (test_end) begin
        if (op == OP_MEAS && meas_cnt != int'(exp_val)) begin
          report_value("fll_clk rising edges", 32'(meas_cnt), 32'(exp_val));
        end
        if (op == OP_LOCK && !rise_seen) report_plain("lock never rose after the write");
        if (op == OP_PWD && c < N_CHANNELS && lock[c] !== exp_val[0]) begin
          report_value("lock", 32'(lock[c]), 32'(exp_val[0]));
        end
        n_tests++;
        if (test_errs == 0) begin
          $display("Test %0d: pass", test_id);
        end else begin
          $display("Test %0d: fail with %0d errors", test_id, test_errs);
          n_fail++;
        end
        n_err     += test_errs;
        test_errs = 0;
        meas_cnt  = 0;
        byp_n     = 0;
        wr_seen   = 1'b0;
        rise_seen = 1'b0;
      end
    end
    fll_d  = fll_clk;
    ref_d  = ref_clk;
    lock_d = lock;
  end

endmodule

// File: tb_pll_cluster.sv
/* Testbench for a four-channel pll_cluster. Rows of the stimulus table
   run in order; all comparing happens in pll_checker. */
`timescale 1ns/10ps

module tb_pll_cluster;

  import cfg_bus_pkg::*;

  localparam int         N_CH     = 4;
  localparam int         N_ROWS   = 11;
  localparam logic [3:0] OP_RDALL = 4'd0;
  localparam logic [3:0] OP_LOOP  = 4'd1;
  localparam logic [3:0] OP_BYP   = 4'd2;
  localparam logic [3:0] OP_MEAS  = 4'd3;
  localparam logic [3:0] OP_LOCK  = 4'd4;
  localparam logic [3:0] OP_PWD   = 4'd5;
  localparam logic [3:0] OP_OOR   = 4'd6;
  localparam logic [3:0] OP_IDLE  = 4'd15;

  typedef struct packed {
    logic [7:0]  id;
    logic [3:0]  op;
    logic [5:0]  chan;
    logic [1:0]  word;
    logic [31:0] data;
    logic        pwd;
    logic        ref_rand;  // ref_clk taken from the LFSR
    logic [15:0] count;     // Cycles to run or wait
    logic [15:0] exp;       // Expected count or delay
  } row_t;

  logic            clk;
  logic            RSTB;
  cfg_req_t        cfg_req;
  cfg_rsp_t        cfg_rsp;
  logic [N_CH-1:0] ref_clk;
  logic [N_CH-1:0] pwd;
  logic [N_CH-1:0] fll_clk;
  logic [N_CH-1:0] lock;
  logic [7:0]      test_id;
  logic [3:0]      chk_op;
  logic [5:0]      chk_chan;
  logic [15:0]     exp_val;
  logic            test_end;
  int              n_tests;
  int              n_fail;
  int              n_err;
  row_t            stim [N_ROWS];
  logic [15:0]     lfsr_state;
  int              cycle_cnt;
  int              cycle_limit;

  pll_cluster #(
    .N_CHANNELS (N_CH)
  ) u_pll_cluster (
    .clk     (clk),
    .RSTB    (RSTB),
    .cfg_req (cfg_req),
    .cfg_rsp (cfg_rsp),
    .ref_clk (ref_clk),
    .pwd     (pwd),
    .fll_clk (fll_clk),
    .lock    (lock)
  );

  pll_checker #(
    .N_CHANNELS (N_CH)
  ) u_checker (
    .clk      (clk),
    .RSTB     (RSTB),
    .cfg_req  (cfg_req),
    .cfg_rsp  (cfg_rsp),
    .ref_clk  (ref_clk),
    .fll_clk  (fll_clk),
    .lock     (lock),
    .test_id  (test_id),
    .op       (chk_op),
    .chan     (chk_chan),
    .exp_val  (exp_val),
    .test_end (test_end),
    .n_tests  (n_tests),
    .n_fail   (n_fail),
    .n_err    (n_err)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      $display("Run stopped after %0d cycles without reaching the end", cycle_cnt);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  function automatic row_t make_row(input int id, input logic [3:0] op, input int ch,
                                    input int wd, input logic [31:0] d, input logic p,
                                    input logic rnd, input int cnt, input int ex);
    row_t r;
    r.id       = 8'(id);
    r.op       = op;
    r.chan     = 6'(ch);
    r.word     = 2'(wd);
    r.data     = d;
    r.pwd      = p;
    r.ref_rand = rnd;
    r.count    = 16'(cnt);
    r.exp      = 16'(ex);
    return r;
  endfunction

  // Galois LFSR, taps 16,14,13,11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic next_bit(output logic b);
    b          = lfsr_state[0];
    lfsr_state = lfsr_step(lfsr_state);
  endtask

  task automatic next_word(output logic [31:0] w);
    logic b;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      next_bit(b);
      w = {w[30:0], b};
    end
  endtask

  task automatic run_cycles(input int n, input int ch, input logic rnd);
    logic b;
    repeat (n) begin
      @(posedge clk);
      #5;
      if (rnd) begin
        next_bit(b);
        ref_clk[ch] = b;
      end
    end
  endtask

  // Holds req until ack or 8 cycles, then leaves one idle edge
  task automatic bus_access(input logic web, input int ch, input int wd,
                            input logic [31:0] d);
    int   n;
    logic acked;
    cfg_req.req   = 1'b1;
    cfg_req.web   = web;
    cfg_req.chan  = 6'(ch);
    cfg_req.word  = pll_cfg_pkg::pll_word_sel_e'(2'(wd));
    cfg_req.wdata = d;
    n     = 0;
    acked = 1'b0;
    while (!acked && n < 8) begin
      @(posedge clk);
      #5;
      n++;
      acked = cfg_rsp.ack;
    end
    cfg_req.req = 1'b0;
    run_cycles(1, 0, 1'b0);
  endtask

  task automatic read_all();
    for (int c = 0; c < N_CH; c++) begin
      for (int w = 0; w < 4; w++) bus_access(1'b1, c, w, 32'h0);
    end
  endtask

  task automatic apply_row(input row_t r);
    logic [31:0] d;
    int          ch;
    int          n;
    ch       = int'(r.chan);
    test_id  = r.id;
    chk_chan = r.chan;
    exp_val  = r.exp;
    chk_op   = (r.op == OP_MEAS) ? OP_IDLE : r.op;  // Count only after settling
    case (r.op)
      OP_RDALL: read_all();
      OP_LOOP: begin
        for (int c = 0; c < N_CH; c++) begin
          for (int w = 0; w < 4; w++) begin
            next_word(d);
            bus_access(1'b0, c, w, d);
          end
        end
        read_all();
      end
      OP_BYP: run_cycles(int'(r.count), ch, r.ref_rand);
      OP_MEAS: begin
        bus_access(1'b0, ch, int'(r.word), r.data);
        run_cycles(8, ch, 1'b0);
        chk_op = OP_MEAS;
        run_cycles(int'(r.count), ch, 1'b0);
      end
      OP_LOCK: begin
        bus_access(1'b0, ch, int'(r.word), r.data);
        n = 0;
        while (!lock[ch] && n < int'(r.count)) begin
          run_cycles(1, ch, 1'b0);
          n++;
        end
        run_cycles(2, ch, 1'b0);
      end
      OP_PWD: begin
        pwd[ch] = r.pwd;
        bus_access(1'b0, ch, int'(r.word), r.data);
        run_cycles(int'(r.count), ch, 1'b0);
      end
      OP_OOR: bus_access(1'b0, ch, int'(r.word), r.data);
      default: run_cycles(int'(r.count), 0, 1'b0);
    endcase
    test_end = 1'b1;
    run_cycles(1, 0, 1'b0);
    test_end = 1'b0;
    chk_op   = OP_IDLE;
    pwd      = '0;
    ref_clk  = '0;
  endtask

  initial begin
    clk        = 1'b0;
    RSTB       = 1'b0;
    cfg_req    = '0;
    ref_clk    = '0;
    pwd        = '0;
    test_id    = '0;
    chk_op     = OP_IDLE;
    chk_chan   = '0;
    exp_val    = '0;
    test_end   = 1'b0;
    cycle_cnt  = 0;
    lfsr_state = 16'd19472;

    stim[0]  = make_row(1, OP_RDALL, 0, 0, 32'h0, 1'b0, 1'b0, 0, 0);
    stim[1]  = make_row(2, OP_BYP, 0, 0, 32'h0, 1'b0, 1'b1, 40, 0);
    stim[2]  = make_row(3, OP_MEAS, 0, 1, 32'h0000_4001, 1'b0, 1'b0, 64, 16);  // 2^22 step
    stim[3]  = make_row(4, OP_MEAS, 0, 1, 32'h1000_4001, 1'b0, 1'b0, 64, 8);   // Prescale 1
    stim[4]  = make_row(5, OP_MEAS, 0, 1, 32'h0000_4000, 1'b0, 1'b0, 64, 0);   // ps0_en clear
    stim[5]  = make_row(6, OP_LOOP, 0, 0, 32'h0, 1'b0, 1'b0, 0, 0);
    stim[6]  = make_row(7, OP_LOCK, 1, 2, 32'd20, 1'b0, 1'b0, 40, 21);
    stim[7]  = make_row(8, OP_LOCK, 2, 2, 32'h4000_0005, 1'b0, 1'b0, 20, 6);
    stim[8]  = make_row(9, OP_PWD, 3, 2, 32'd3, 1'b1, 1'b0, 30, 0);
    stim[9]  = make_row(10, OP_OOR, 5, 0, 32'hDEAD_BEEF, 1'b0, 1'b0, 0, 0);
    stim[10] = make_row(11, OP_RDALL, 0, 0, 32'h0, 1'b0, 1'b0, 0, 0);

    // Each row gets its own count plus room for up to 32 bus accesses
    cycle_limit = 60;
    for (int i = 0; i < N_ROWS; i++) cycle_limit += int'(stim[i].count) + 140;

    repeat (10) @(posedge clk);
    #5;
    RSTB = 1'b1;
    run_cycles(2, 0, 1'b0);
    for (int i = 0; i < N_ROWS; i++) apply_row(stim[i]);
    run_cycles(2, 0, 1'b0);

    $display("Totals: %0d tests run, %0d failed, %0d errors", n_tests, n_fail, n_err);
    if (n_fail == 0 && n_err == 0 && n_tests == N_ROWS) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: pll_cluster.f
pll_cfg_pkg.sv
cfg_bus_pkg.sv
cfg_bus_decoder.sv
pll_nco.sv
pll_channel.sv
cfg_status_merge.sv
pll_cluster.sv
pll_checker.sv
tb_pll_cluster.sv

// File: Makefile
# Verilator build and run for the pll_cluster testbench

VERILATOR ?= verilator
TOP       ?= tb_pll_cluster
FLIST     ?= pll_cluster.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= ALL TESTS PASSED

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# Status follows the search for the pass message
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
